// File: design/rvPkg.sv
/*
 * Shared sizes, encodings and pipeline bundles for the three-stage
 * RV32I subset core. Design and testbench files refer to these
 * through rvPkg:: scoped names.
 */
`default_nettype none

package rvPkg;

	localparam int XLEN = 32;
	localparam int REG_ID_W = 5;
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW = $clog2(DMEM_WORDS);
	localparam logic [XLEN-1:0] PC_RESET = '0;
	// the only SYSTEM word the core accepts
	localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		SYSTEM = 7'b1110011
	} opcodeE;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		PASS_B
	} aluOpE;

	typedef struct packed {
		aluOpE aluOp;
		logic  useImm;
		logic  regWen;
		logic  memRen;
		logic  memWen;
		logic  isBranch;
		logic  branchNe;
		logic  isJal;
		logic  isHalt;
		logic  illegal;
	} ctrlS;

	// fetch to decode-execute
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] inst;
	} fetchS;

	// execute to memory-writeback
	typedef struct packed {
		logic                valid;
		logic [XLEN-1:0]     pc;
		logic [REG_ID_W-1:0] rd;
		ctrlS                ctrl;
		logic [XLEN-1:0]     aluResult;
		logic [XLEN-1:0]     storeData;
	} memWbS;

	// commit report, also used as the forwarding bundle
	typedef struct packed {
		logic                valid;
		logic [XLEN-1:0]     pc;
		logic                regWen;
		logic [REG_ID_W-1:0] rd;
		logic [XLEN-1:0]     wdata;
		logic                illegal;
		logic                halt;
	} retireS;

endpackage

`default_nettype wire

// File: design/alu.sv
/*
 * Integer ALU for the core. Purely combinational, the operation is
 * picked by the ALU opcode from the decoder. SLT compares signed.
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire logic [rvPkg::XLEN-1:0] a,
	input  wire logic [rvPkg::XLEN-1:0] b,
	input  wire rvPkg::aluOpE           op,
	output logic [rvPkg::XLEN-1:0]      y
);

	always_comb begin
		case (op)
			rvPkg::ADD:    y = a + b;
			rvPkg::SUB:    y = a - b;
			rvPkg::AND:    y = a & b;
			rvPkg::OR:     y = a | b;
			rvPkg::XOR:    y = a ^ b;
			rvPkg::SLT:    y = {{(rvPkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			// lui passes the shifted immediate through
			rvPkg::PASS_B: y = b;
			default:       y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/registerFile.sv
/*
 * 32 x 32 integer register file. Reads are asynchronous, the single
 * write port is clocked, x0 always reads zero.
 */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  wire logic                       clk,
	input  wire logic [rvPkg::REG_ID_W-1:0] rs1,
	input  wire logic [rvPkg::REG_ID_W-1:0] rs2,
	output logic [rvPkg::XLEN-1:0]          rdata1,
	output logic [rvPkg::XLEN-1:0]          rdata2,
	input  wire logic                       wen,
	input  wire logic [rvPkg::REG_ID_W-1:0] waddr,
	input  wire logic [rvPkg::XLEN-1:0]     wdata
);

	logic [rvPkg::XLEN-1:0] regs [2**rvPkg::REG_ID_W];

	// same-cycle writes are picked up by forwarding, not here
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: design/decoder.sv
/*
 * Instruction decoder for the supported RV32I subset. Splits out the
 * register ids, builds the sign-extended immediate and the control
 * bundle. Anything outside the subset is flagged illegal.
 */
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  wire logic [rvPkg::XLEN-1:0] inst,
	output logic [rvPkg::REG_ID_W-1:0]  rd,
	output logic [rvPkg::REG_ID_W-1:0]  rs1,
	output logic [rvPkg::REG_ID_W-1:0]  rs2,
	output logic [rvPkg::XLEN-1:0]      imm,
	output rvPkg::ctrlS                 ctrl
);

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [rvPkg::XLEN-1:0] immI;
	logic [rvPkg::XLEN-1:0] immS;
	logic [rvPkg::XLEN-1:0] immB;
	logic [rvPkg::XLEN-1:0] immU;
	logic [rvPkg::XLEN-1:0] immJ;

	assign rd = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = rvPkg::ADD;
		imm = '0;
		case (rvPkg::opcodeE'(inst[6:0]))
			rvPkg::OP: begin
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: ctrl.aluOp = rvPkg::ADD;
					{7'b0100000, 3'b000}: ctrl.aluOp = rvPkg::SUB;
					{7'b0000000, 3'b111}: ctrl.aluOp = rvPkg::AND;
					{7'b0000000, 3'b110}: ctrl.aluOp = rvPkg::OR;
					{7'b0000000, 3'b100}: ctrl.aluOp = rvPkg::XOR;
					{7'b0000000, 3'b010}: ctrl.aluOp = rvPkg::SLT;
					default: ctrl.illegal = 1'b1;
				endcase
				ctrl.regWen = !ctrl.illegal;
			end
			rvPkg::OP_IMM: begin
				// addi only
				ctrl.illegal = (funct3 != 3'b000);
				ctrl.useImm = !ctrl.illegal;
				ctrl.regWen = !ctrl.illegal;
				imm = immI;
			end
			rvPkg::LUI: begin
				ctrl.aluOp = rvPkg::PASS_B;
				ctrl.useImm = 1'b1;
				ctrl.regWen = 1'b1;
				imm = immU;
			end
			rvPkg::LOAD: begin
				ctrl.illegal = (funct3 != 3'b010);
				ctrl.useImm = !ctrl.illegal;
				ctrl.regWen = !ctrl.illegal;
				ctrl.memRen = !ctrl.illegal;
				imm = immI;
			end
			rvPkg::STORE: begin
				ctrl.illegal = (funct3 != 3'b010);
				ctrl.useImm = !ctrl.illegal;
				ctrl.memWen = !ctrl.illegal;
				imm = immS;
			end
			rvPkg::BRANCH: begin
				// beq and bne, compared by subtraction
				ctrl.illegal = (funct3[2:1] != 2'b00);
				ctrl.aluOp = rvPkg::SUB;
				ctrl.isBranch = !ctrl.illegal;
				ctrl.branchNe = funct3[0] && !ctrl.illegal;
				imm = immB;
			end
			rvPkg::JAL: begin
				ctrl.isJal = 1'b1;
				ctrl.regWen = 1'b1;
				imm = immJ;
			end
			rvPkg::SYSTEM: begin
				ctrl.isHalt = (inst == rvPkg::EBREAK_WORD);
				ctrl.illegal = !ctrl.isHalt;
			end
			default: ctrl.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: design/fetchStage.sv
/*
 * Fetch stage. Holds the program counter, drives the fetch address
 * and registers the returned word for decode-execute. A redirect or
 * halt squashes the registered word; once halted the pc freezes.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic [rvPkg::XLEN-1:0] inst,
	input  wire logic                   redirect,
	input  wire logic [rvPkg::XLEN-1:0] redirectPc,
	input  wire logic                   haltSeen,
	output logic [rvPkg::XLEN-1:0]      pcFetch,
	output rvPkg::fetchS                fetched,
	output logic                        halted
);

	logic [rvPkg::XLEN-1:0] pc;
	logic [rvPkg::XLEN-1:0] pcNext;
	logic freeze;

	// stop advancing as soon as ebreak shows up in execute
	assign freeze = halted || haltSeen;
	assign pcNext = redirect ? redirectPc : pc + rvPkg::XLEN'(4);
	assign pcFetch = pc;

	always_ff @(posedge clk) begin
		fetched.pc <= pc;
		fetched.inst <= inst;
		if (rst) begin
			pc <= rvPkg::PC_RESET;
			halted <= 1'b0;
			fetched.valid <= 1'b0;
		end else begin
			if (!freeze) begin
				pc <= pcNext;
			end
			if (haltSeen) begin
				halted <= 1'b1;
			end
			// younger word is dropped on a taken branch or jump
			fetched.valid <= !(freeze || redirect);
		end
	end

endmodule

`default_nettype wire

// File: design/executeStage.sv
/*
 * Decode-execute stage. Decodes the fetched word, forwards from
 * memory-writeback, runs the ALU, resolves branches and JAL, and
 * registers the result into the execute-to-memory bundle.
 */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire rvPkg::fetchS           fetched,
	input  wire rvPkg::retireS          fwd,
	output logic                        redirect,
	output logic [rvPkg::XLEN-1:0]      redirectPc,
	output logic                        haltSeen,
	output rvPkg::memWbS                toMem,
	output logic [rvPkg::REG_ID_W-1:0]  rs1,
	output logic [rvPkg::REG_ID_W-1:0]  rs2,
	input  wire logic [rvPkg::XLEN-1:0] rdata1,
	input  wire logic [rvPkg::XLEN-1:0] rdata2
);

	logic [rvPkg::REG_ID_W-1:0] rd;
	logic [rvPkg::XLEN-1:0] imm;
	rvPkg::ctrlS ctrl;
	logic fwdActive;
	logic [rvPkg::XLEN-1:0] opA;
	logic [rvPkg::XLEN-1:0] opB;
	logic [rvPkg::XLEN-1:0] aluB;
	logic [rvPkg::XLEN-1:0] aluY;
	logic [rvPkg::XLEN-1:0] result;
	logic taken;

	decoder uDecoder (
		.inst (fetched.inst),
		.rd   (rd),
		.rs1  (rs1),
		.rs2  (rs2),
		.imm  (imm),
		.ctrl (ctrl)
	);

	// the retiring instruction is one ahead, also covers load-use
	assign fwdActive = fwd.valid && fwd.regWen && (fwd.rd != '0);
	assign opA = (fwdActive && fwd.rd == rs1) ? fwd.wdata : rdata1;
	assign opB = (fwdActive && fwd.rd == rs2) ? fwd.wdata : rdata2;
	assign aluB = ctrl.useImm ? imm : opB;

	alu uAlu (
		.a  (opA),
		.b  (aluB),
		.op (ctrl.aluOp),
		.y  (aluY)
	);

	// zero difference means equal operands
	assign taken = ctrl.isBranch && ((aluY == '0) != ctrl.branchNe);
	assign redirect = fetched.valid && (taken || ctrl.isJal);
	assign redirectPc = fetched.pc + imm;
	assign haltSeen = fetched.valid && ctrl.isHalt;
	assign result = ctrl.isJal ? fetched.pc + rvPkg::XLEN'(4) : aluY;

	always_ff @(posedge clk) begin
		toMem.pc <= fetched.pc;
		toMem.rd <= rd;
		toMem.ctrl <= ctrl;
		toMem.aluResult <= result;
		toMem.storeData <= opB;
		if (rst) begin
			toMem.valid <= 1'b0;
		end else begin
			toMem.valid <= fetched.valid;
		end
	end

endmodule

`default_nettype wire

// File: design/memStage.sv
/*
 * Memory-writeback stage. Holds the 64-word data memory, picks the
 * register write value and forms the retire report, which also feeds
 * forwarding in decode-execute.
 */
`timescale 1ns/1ps
`default_nettype none

module memStage (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire rvPkg::memWbS          fromExe,
	output rvPkg::retireS              retire,
	output logic                       wen,
	output logic [rvPkg::REG_ID_W-1:0] waddr,
	output logic [rvPkg::XLEN-1:0]     wdata
);

	logic [rvPkg::XLEN-1:0] dmem [rvPkg::DMEM_WORDS];
	logic [rvPkg::DMEM_AW-1:0] wordIdx;
	logic [rvPkg::XLEN-1:0] loadData;
	logic [rvPkg::XLEN-1:0] result;

	// word accesses only, low two address bits ignored
	assign wordIdx = fromExe.aluResult[rvPkg::DMEM_AW+1:2];
	assign loadData = dmem[wordIdx];

	always_ff @(posedge clk) begin
		if (!rst && fromExe.valid && fromExe.ctrl.memWen) begin
			dmem[wordIdx] <= fromExe.storeData;
		end
	end

	assign result = fromExe.ctrl.memRen ? loadData : fromExe.aluResult;

	// register write happens at the end of this cycle
	assign wen = fromExe.valid && fromExe.ctrl.regWen;
	assign waddr = fromExe.rd;
	assign wdata = result;

	always_comb begin
		retire.valid = fromExe.valid;
		retire.pc = fromExe.pc;
		retire.regWen = fromExe.ctrl.regWen;
		retire.rd = fromExe.rd;
		retire.wdata = result;
		retire.illegal = fromExe.ctrl.illegal;
		retire.halt = fromExe.ctrl.isHalt;
	end

endmodule

`default_nettype wire

// File: design/rvCpu.sv
/*
 * Top level of the three-stage core. The instruction store sits
 * outside and answers pcFetch combinationally on inst. Commits are
 * reported on retire, halted rises after EBREAK.
 */
`timescale 1ns/1ps
`default_nettype none

module rvCpu (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic [rvPkg::XLEN-1:0] inst,
	output logic [rvPkg::XLEN-1:0]      pcFetch,
	output rvPkg::retireS               retire,
	output logic                        halted
);

	rvPkg::fetchS fetched;
	rvPkg::memWbS toMem;
	logic redirect;
	logic [rvPkg::XLEN-1:0] redirectPc;
	logic haltSeen;
	logic [rvPkg::REG_ID_W-1:0] rs1;
	logic [rvPkg::REG_ID_W-1:0] rs2;
	logic [rvPkg::XLEN-1:0] rdata1;
	logic [rvPkg::XLEN-1:0] rdata2;
	logic rfWen;
	logic [rvPkg::REG_ID_W-1:0] rfWaddr;
	logic [rvPkg::XLEN-1:0] rfWdata;

	fetchStage uFetch (
		.clk        (clk),
		.rst        (rst),
		.inst       (inst),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.haltSeen   (haltSeen),
		.pcFetch    (pcFetch),
		.fetched    (fetched),
		.halted     (halted)
	);

	executeStage uExecute (
		.clk        (clk),
		.rst        (rst),
		.fetched    (fetched),
		.fwd        (retire),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.haltSeen   (haltSeen),
		.toMem      (toMem),
		.rs1        (rs1),
		.rs2        (rs2),
		.rdata1     (rdata1),
		.rdata2     (rdata2)
	);

	// read by execute, written back from memory-writeback
	registerFile uRegFile (
		.clk    (clk),
		.rs1    (rs1),
		.rs2    (rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wen    (rfWen),
		.waddr  (rfWaddr),
		.wdata  (rfWdata)
	);

	memStage uMem (
		.clk     (clk),
		.rst     (rst),
		.fromExe (toMem),
		.retire  (retire),
		.wen     (rfWen),
		.waddr   (rfWaddr),
		.wdata   (rfWdata)
	);

endmodule

`default_nettype wire

// File: tests/rvCpu_assert.sv
/*
 * Concurrent assertions on pipeline invariants of the core, bound
 * into rvCpu. failCount is read by the testbench at the end of the run.
 */
`timescale 1ns/1ps
`default_nettype none

module rvCpuAssert (
	input wire logic                   clk,
	input wire logic                   rst,
	input wire logic [rvPkg::XLEN-1:0] pcFetch,
	input wire rvPkg::retireS          retire,
	input wire logic                   halted
);

	int failCount = 0;

	// a reset cycle leaves nothing in flight
	resetQuiet: assert property (@(posedge clk) rst |=> !retire.valid)
		else begin
			$error("retire.valid high right after a reset cycle");
			failCount++;
		end

	haltFreeze: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pcFetch))
		else begin
			$error("pcFetch moved while halted");
			failCount++;
		end

	// illegal words never write a register, x0 included
	illegalNoWrite: assert property (@(posedge clk) disable iff (rst)
		retire.valid && retire.illegal |-> !retire.regWen)
		else begin
			$error("illegal retirement with regWen set, rd %h", retire.rd);
			failCount++;
		end

	haltIsLast: assert property (@(posedge clk) disable iff (rst)
		retire.valid && retire.halt |=> !retire.valid)
		else begin
			$error("retirement in the cycle after EBREAK");
			failCount++;
		end

endmodule

bind rvCpu rvCpuAssert uAssert (
	.clk     (clk),
	.rst     (rst),
	.pcFetch (pcFetch),
	.retire  (retire),
	.halted  (halted)
);

`default_nettype wire

// File: tests/rvCpuChecker.sv
/*
 * Sequential instruction-set model of the RV32I subset. It reads the
 * program array, steps one instruction per retirement of the core
 * and compares pc, flags, rd and write data. Raises done after halt.
 */
`timescale 1ns/1ps
`default_nettype none

module rvCpuChecker (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic [31:0] prog [256],
	input  wire rvPkg::retireS retire,
	input  wire logic        halted,
	output logic             done,
	output int               errorCount
);

	logic [31:0] regs [32];
	logic [31:0] mem [64];
	logic [31:0] modelPc;
	logic haltRetired;
	int quietCycles;
	rvPkg::retireS expected;

	task automatic compareField(string name, logic [31:0] got, logic [31:0] want);
		if (got !== want) begin
			$display("[ERROR] %s: got %h, expected %h (pc %h)", name, got, want, modelPc);
			errorCount++;
		end
	endtask

	// executes the word at modelPc and returns what should retire
	task automatic modelStep(output rvPkg::retireS exp);
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] nextPc;
		w = prog[modelPc[9:2]];
		a = regs[w[19:15]];
		b = regs[w[24:20]];
		exp = '0;
		exp.valid = 1'b1;
		exp.pc = modelPc;
		exp.rd = w[11:7];
		nextPc = modelPc + 32'd4;
		case (w[6:0])
			rvPkg::OP: begin
				exp.regWen = 1'b1;
				case ({w[31:25], w[14:12]})
					{7'h00, 3'b000}: exp.wdata = a + b;
					{7'h20, 3'b000}: exp.wdata = a - b;
					{7'h00, 3'b111}: exp.wdata = a & b;
					{7'h00, 3'b110}: exp.wdata = a | b;
					{7'h00, 3'b100}: exp.wdata = a ^ b;
					{7'h00, 3'b010}: exp.wdata = {31'b0, $signed(a) < $signed(b)};
					default: begin
						exp.regWen = 1'b0;
						exp.illegal = 1'b1;
					end
				endcase
			end
			rvPkg::OP_IMM: begin
				exp.illegal = (w[14:12] != 3'b000);
				exp.regWen = !exp.illegal;
				exp.wdata = a + {{20{w[31]}}, w[31:20]};
			end
			rvPkg::LUI: begin
				exp.regWen = 1'b1;
				exp.wdata = {w[31:12], 12'b0};
			end
			rvPkg::LOAD: begin
				exp.illegal = (w[14:12] != 3'b010);
				exp.regWen = !exp.illegal;
				addr = a + {{20{w[31]}}, w[31:20]};
				exp.wdata = mem[addr[7:2]];
			end
			rvPkg::STORE: begin
				exp.illegal = (w[14:12] != 3'b010);
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				if (!exp.illegal) begin
					mem[addr[7:2]] = b;
				end
			end
			rvPkg::BRANCH: begin
				exp.illegal = (w[14:13] != 2'b00);
				if (!exp.illegal && ((a == b) != w[12])) begin
					nextPc = modelPc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				end
			end
			rvPkg::JAL: begin
				exp.regWen = 1'b1;
				exp.wdata = modelPc + 32'd4;
				nextPc = modelPc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			// ebreak is the only accepted system word
			rvPkg::SYSTEM: begin
				exp.halt = (w == 32'h0010_0073);
				exp.illegal = !exp.halt;
			end
			default: exp.illegal = 1'b1;
		endcase
		if (exp.regWen && exp.rd != 5'd0) begin
			regs[exp.rd] = exp.wdata;
		end
		modelPc = nextPc;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			foreach (regs[i]) regs[i] = '0;
			foreach (mem[i]) mem[i] = '0;
			modelPc = rvPkg::PC_RESET;
			haltRetired = 1'b0;
			quietCycles = 0;
			done = 1'b0;
			errorCount = 0;
		end else if (!done) begin
			if (retire.valid !== 1'b0) begin
				if (haltRetired) begin
					$display("unexpected retirement at pc %h after EBREAK", retire.pc);
					errorCount++;
				end else begin
					compareField("retire.valid", retire.valid, 32'd1);
					compareField("retire.pc", retire.pc, modelPc);
					modelStep(expected);
					compareField("retire.illegal", retire.illegal, expected.illegal);
					compareField("retire.halt", retire.halt, expected.halt);
					compareField("retire.regWen", retire.regWen, expected.regWen);
					if (expected.regWen) begin
						compareField("retire.rd", retire.rd, expected.rd);
						compareField("retire.wdata", retire.wdata, expected.wdata);
					end
					haltRetired = expected.halt;
				end
			end
			// watch a few quiet cycles after ebreak before calling it done
			if (haltRetired) begin
				quietCycles++;
				if (quietCycles == 4) begin
					compareField("halted", halted, 32'd1);
					done = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/rvCpuTb.sv
/*
 * Testbench for the three-stage core. Builds a random program from a
 * fixed seed, serves it as the instruction store, and lets the
 * checker compare every retirement against its model.
 */
`timescale 1ns/1ps
`default_nettype none

module rvCpuTb;

	logic clk;
	logic rst;
	logic [31:0] inst;
	logic [31:0] pcFetch;
	rvPkg::retireS retire;
	logic halted;
	logic [31:0] prog [256];
	logic checkDone;
	int checkErrors;

	rvCpu DUT (
		.clk     (clk),
		.rst     (rst),
		.inst    (inst),
		.pcFetch (pcFetch),
		.retire  (retire),
		.halted  (halted)
	);

	rvCpuChecker uChecker (
		.clk        (clk),
		.rst        (rst),
		.prog       (prog),
		.retire     (retire),
		.halted     (halted),
		.done       (checkDone),
		.errorCount (checkErrors)
	);

	always #5 clk = ~clk;

	// instruction store answers the current fetch address
	always @(negedge clk) begin
		inst <= prog[pcFetch[9:2]];
	end

	// small register window so that dependencies are frequent
	function automatic logic [4:0] regPick();
		return 5'($urandom_range(0, 7));
	endfunction

	function automatic rvPkg::opcodeE pickOpcode();
		case ($urandom_range(0, 6))
			0: return rvPkg::OP;
			1: return rvPkg::OP_IMM;
			2: return rvPkg::LUI;
			3: return rvPkg::LOAD;
			4: return rvPkg::STORE;
			5: return rvPkg::BRANCH;
			default: return rvPkg::JAL;
		endcase
	endfunction

	// funct7 and funct3 of the register-register ops
	function automatic logic [9:0] pickFunct();
		case ($urandom_range(0, 5))
			0: return {7'h00, 3'b000};
			1: return {7'h20, 3'b000};
			2: return {7'h00, 3'b111};
			3: return {7'h00, 3'b110};
			4: return {7'h00, 3'b100};
			default: return {7'h00, 3'b010};
		endcase
	endfunction

	function automatic logic [31:0] storeWord(logic [11:0] imm, logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rvPkg::STORE};
	endfunction

	// load from the same x0-based word as the given store
	function automatic logic [31:0] reloadWord(logic [31:0] storeInst);
		return {storeInst[31:25], storeInst[11:7], 5'd0, 3'b010, regPick(), rvPkg::LOAD};
	endfunction

	function automatic logic [31:0] branchWord(logic [12:0] off, logic [2:0] f3);
		return {off[12], off[10:5], regPick(), regPick(), f3, off[4:1], off[11], rvPkg::BRANCH};
	endfunction

	function automatic logic [31:0] jalWord(logic [20:0] off, logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::JAL};
	endfunction

	function automatic logic [31:0] randomWord(int idx);
		logic [31:0] r;
		logic [4:0] rd;
		logic [9:0] funct;
		int hop;
		r = $urandom();
		rd = regPick();
		funct = pickFunct();
		hop = $urandom_range(2, 8);
		if ($urandom_range(0, 39) == 0) begin
			// custom-0 major opcode lies outside the subset
			return {r[31:7], 7'b0001011};
		end
		case (pickOpcode())
			rvPkg::OP: return {funct[9:3], regPick(), regPick(), funct[2:0], rd, rvPkg::OP};
			rvPkg::OP_IMM: return {r[11:0], regPick(), 3'b000, rd, rvPkg::OP_IMM};
			rvPkg::LUI: return {r[31:12], rd, rvPkg::LUI};
			rvPkg::LOAD: return {12'($urandom_range(0, 63) * 4), 5'd0, 3'b010, rd, rvPkg::LOAD};
			rvPkg::STORE: return storeWord(12'($urandom_range(0, 63) * 4), regPick());
			rvPkg::BRANCH: begin
				if (idx + hop > 255) begin
					return {12'd0, 5'd0, 3'b000, 5'd0, rvPkg::OP_IMM};
				end
				return branchWord(13'(hop * 4), {2'b00, r[0]});
			end
			default: begin
				if (idx + hop > 255) begin
					return {12'd0, 5'd0, 3'b000, 5'd0, rvPkg::OP_IMM};
				end
				return jalWord(21'(hop * 4), rd);
			end
		endcase
	endfunction

	// prologue defines every register and memory word, then random code
	task automatic buildProgram();
		int pos;
		for (int i = 1; i < 32; i++) begin
			prog[i - 1] = {12'($urandom_range(0, 4095)), 5'd0, 3'b000, 5'(i), rvPkg::OP_IMM};
		end
		for (int w = 0; w < 64; w++) begin
			prog[31 + w] = storeWord(12'(w * 4), 5'($urandom_range(1, 31)));
		end
		// the first random slot always runs and holds an illegal word
		prog[95] = {25'($urandom()), 7'b0001011};
		pos = 96;
		while (pos < 255) begin
			prog[pos] = randomWord(pos);
			// half of the stores are read back by the very next word
			if (prog[pos][6:0] == rvPkg::STORE && pos < 254
				&& $urandom_range(0, 1) == 1) begin
				pos++;
				prog[pos] = reloadWord(prog[pos - 1]);
			end
			pos++;
		end
		prog[255] = rvPkg::EBREAK_WORD;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inst = '0;
		void'($urandom(52));
		buildProgram();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		wait (checkDone === 1'b1);
		$display("checker errors: %0d, assertion failures: %0d",
			checkErrors, DUT.uAssert.failCount);
		if (checkErrors == 0 && DUT.uAssert.failCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// four cycles per program word at 10 ns, plus the reset cycles
	initial begin
		#(4 * 256 * 10 + 4 * 10);
		$display("timeout: the core did not halt and retire EBREAK in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
design/rvPkg.sv
design/alu.sv
design/registerFile.sv
design/decoder.sv
design/fetchStage.sv
design/executeStage.sv
design/memStage.sv
design/rvCpu.sv
tests/rvCpu_assert.sv
tests/rvCpuChecker.sv
tests/rvCpuTb.sv
